//--- mii_arp_macros.svh
`ifndef MII_ARP_MACROS_SVH
`define MII_ARP_MACROS_SVH

// receive buffer, holds preamble/SFD plus the start of the frame
`define RX_BUF_BYTES 64
`define RX_ADDR_W 6

// reply frame, preamble included
`define TX_FRAME_BYTES 50
`define TX_ADDR_W 6

// ethertype position in the raw buffer (8 preamble bytes + 12 MAC bytes)
`define ETYPE_HI_OFS 20
`define ETYPE_LO_OFS 21

// ethertype value for ARP
`define ETYPE_ARP_HI 8'h08
`define ETYPE_ARP_LO 8'h06

`endif

//--- mii_arp_pkg.sv
`include "mii_arp_macros.svh"

package mii_arp_pkg;

    // table word, copy view
    // src is the receive buffer byte to copy
    typedef struct packed {
        logic       is_lit;
        logic [6:0] dst;
        logic [7:0] src;
    } reply_copy_t;

    // table word, literal view
    typedef struct packed {
        logic       is_lit;
        logic [6:0] dst;
        logic [7:0] value;
    } reply_lit_t;

    // is_lit sits in the same bit in both views and picks the one to use
    typedef union packed {
        reply_copy_t copy;
        reply_lit_t  lit;
    } reply_op_u;

    // transmit buffer write port
    typedef struct packed {
        logic                  wr;
        logic [`TX_ADDR_W-1:0] addr;
        logic [7:0]            data;
    } tx_wr_t;

    // frame_ready stays up from frame end until released
    typedef struct packed {
        logic                frame_ready;
        logic [`RX_ADDR_W:0] len;
    } rx_status_t;

endpackage

//--- mii_rx_capture.sv
`include "mii_arp_macros.svh"

module mii_rx_capture (
    input  logic                    i_sys_clk,
    input  logic                    i_nreset,
    input  logic                    i_rx_enable,
    input  logic                    i_rx_dv,
    input  logic [3:0]              i_rx_data,
    input  logic                    i_release,
    input  logic [`RX_ADDR_W-1:0]   i_rd_addr,
    output mii_arp_pkg::rx_status_t o_status,
    output logic [7:0]              o_rd_data
);

    logic [7:0]          rx_buf [`RX_BUF_BYTES];
    logic [3:0]          low_nib;
    logic                last_dv;
    logic                accepting;
    logic                half_q;
    logic [`RX_ADDR_W:0] byte_cnt;

    logic                start;
    logic                take;
    logic                nib_hi;
    logic [`RX_ADDR_W:0] cur_byte;

    // first cycle of dv high opens a frame
    assign start = i_rx_dv && !last_dv;

    // accept decision made once at frame start, then held for the frame
    assign take = i_rx_dv && (start ? (i_rx_enable && !o_status.frame_ready) : accepting);

    // at frame start the pairing and byte count restart
    assign nib_hi   = !start && half_q;
    assign cur_byte = start ? '0 : byte_cnt;

    // buffer and read port
    always_ff @(posedge i_sys_clk) begin
        if (take && !nib_hi) begin
            low_nib <= i_rx_data;
        end
        // low nibble arrives first
        if (take && nib_hi && cur_byte < `RX_BUF_BYTES) begin
            rx_buf[cur_byte[`RX_ADDR_W-1:0]] <= {i_rx_data, low_nib};
        end
        // registered read, data one cycle after address
        o_rd_data <= rx_buf[i_rd_addr];
    end

    always_ff @(posedge i_sys_clk) begin
        if (!i_nreset) begin
            last_dv               <= 1'b0;
            accepting             <= 1'b0;
            half_q                <= 1'b0;
            byte_cnt              <= '0;
            o_status.frame_ready  <= 1'b0;
        end else begin
            last_dv   <= i_rx_dv;
            accepting <= take;

            if (take) begin
                half_q   <= ~nib_hi;
                byte_cnt <= cur_byte;
                // count past the buffer end, saturate at all ones
                if (nib_hi && !(&cur_byte)) begin
                    byte_cnt <= cur_byte + 1'b1;
                end
            end

            // frame end is the first dv low after an accepted frame
            if (i_release) begin
                o_status.frame_ready <= 1'b0;
            end else if (accepting && !i_rx_dv) begin
                o_status.frame_ready <= 1'b1;
                o_status.len         <= byte_cnt;
            end
        end
    end

endmodule

//--- arp_reply_rom.sv
`include "mii_arp_macros.svh"

module arp_reply_rom (
    input  logic [`TX_ADDR_W-1:0]  i_step,
    output mii_arp_pkg::reply_op_u o_op
);

    // our own addresses
    localparam logic [47:0] OWN_MAC = 48'h1234_5678_9abc;
    localparam logic [31:0] OWN_IP  = {8'd10, 8'd69, 8'd69, 8'd42};

    // literal bytes for destinations 8 to 39, first byte in the top bits
    // broadcast dst, src MAC, ethertype, htype/ptype/hlen/plen/oper, sender MAC and IP
    localparam logic [255:0] LIT_BYTES = {
        {6{8'hff}},
        OWN_MAC,
        `ETYPE_ARP_HI,
        `ETYPE_ARP_LO,
        64'h0001_0800_0604_0002,
        OWN_MAC,
        OWN_IP
    };

    logic [4:0] lit_idx;

    assign lit_idx = 5'(i_step - 6'd8);

    always_comb begin
        // destination always equals the step
        o_op.lit.is_lit = 1'b1;
        o_op.lit.dst    = {1'b0, i_step};
        o_op.lit.value  = 8'h00;

        if (i_step < 6'd8) begin
            // preamble and SFD copied through
            o_op.copy.is_lit = 1'b0;
            o_op.copy.src    = {2'b00, i_step};
        end else if (i_step < 6'd40) begin
            o_op.lit.value = LIT_BYTES[8'd255 - {lit_idx, 3'b000} -: 8];
        end else if (i_step < `TX_FRAME_BYTES) begin
            // target MAC and IP from the request's sender fields, bytes 30 to 39
            o_op.copy.is_lit = 1'b0;
            o_op.copy.src    = 8'(i_step - 6'd10);
        end
    end

endmodule

//--- arp_responder.sv
`include "mii_arp_macros.svh"

module arp_responder (
    input  logic                    i_sys_clk,
    input  logic                    i_nreset,
    input  mii_arp_pkg::rx_status_t i_status,
    input  logic [7:0]              i_rd_data,
    input  logic                    i_tx_busy,
    output logic [`RX_ADDR_W-1:0]   o_rd_addr,
    output logic                    o_release,
    output mii_arp_pkg::tx_wr_t     o_tx_wr,
    output logic                    o_tx_start
);

    import mii_arp_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ_TYPE,
        S_DISPATCH,
        S_WALK,
        S_SEND,
        S_FINISH
    } state_t;

    state_t                state;
    logic [1:0]            type_cnt;
    logic [15:0]           eth_type;
    logic [`TX_ADDR_W-1:0] step;
    logic                  phase;
    reply_op_u             op;

    arp_reply_rom u_rom (
        .i_step (step),
        .o_op   (op)
    );

    // read address straight from state and table
    // so the byte is back in time for the second half of a step
    always_comb begin
        o_rd_addr = `RX_ADDR_W'(`ETYPE_LO_OFS);
        if (state == S_WALK) begin
            o_rd_addr = op.copy.src[`RX_ADDR_W-1:0];
        end else if (state == S_READ_TYPE && type_cnt == 2'd0) begin
            o_rd_addr = `RX_ADDR_W'(`ETYPE_HI_OFS);
        end
    end

    // one cycle in finish frees the receive buffer
    assign o_release = (state == S_FINISH);

    always_ff @(posedge i_sys_clk) begin
        if (!i_nreset) begin
            state      <= S_IDLE;
            type_cnt   <= 2'd0;
            step       <= '0;
            phase      <= 1'b0;
            o_tx_start <= 1'b0;
            o_tx_wr.wr <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            o_tx_wr.wr <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (i_status.frame_ready) begin
                        state    <= S_READ_TYPE;
                        type_cnt <= 2'd0;
                    end
                end

                // three cycles, hi byte lands on the second, lo on the third
                S_READ_TYPE: begin
                    type_cnt <= type_cnt + 2'd1;
                    if (type_cnt == 2'd1) begin
                        eth_type[15:8] <= i_rd_data;
                    end
                    if (type_cnt == 2'd2) begin
                        eth_type[7:0] <= i_rd_data;
                        state         <= S_DISPATCH;
                    end
                end

                S_DISPATCH: begin
                    // too short to hold an ethertype means stale buffer bytes
                    if (eth_type == {`ETYPE_ARP_HI, `ETYPE_ARP_LO}
                            && i_status.len > `ETYPE_LO_OFS) begin
                        state <= S_WALK;
                        step  <= '0;
                        phase <= 1'b0;
                    end else begin
                        state <= S_FINISH;
                    end
                end

                // phase 0 reads, phase 1 writes
                S_WALK: begin
                    phase <= ~phase;
                    if (phase) begin
                        o_tx_wr.wr   <= 1'b1;
                        o_tx_wr.addr <= op.lit.dst[`TX_ADDR_W-1:0];
                        o_tx_wr.data <= op.lit.is_lit ? op.lit.value : i_rd_data;
                        if (step == `TX_ADDR_W'(`TX_FRAME_BYTES - 1)) begin
                            state      <= S_SEND;
                            o_tx_start <= 1'b1;
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                end

                // busy only shows up the cycle after start
                S_SEND: begin
                    if (!o_tx_start && !i_tx_busy) begin
                        state <= S_FINISH;
                    end
                end

                S_FINISH: begin
                    state <= S_IDLE;
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

//--- frame_sender.sv
`include "mii_arp_macros.svh"

module frame_sender (
    input  logic                i_sys_clk,
    input  logic                i_nreset,
    input  mii_arp_pkg::tx_wr_t i_wr,
    input  logic                i_start,
    output logic                o_busy,
    output logic                o_tx_valid,
    output logic [7:0]          o_tx_data
);

    logic [7:0]            tx_buf [`TX_FRAME_BYTES];
    logic [`TX_ADDR_W-1:0] rd_idx;

    // buffer fill from the responder, data out while streaming
    always_ff @(posedge i_sys_clk) begin
        if (i_wr.wr) begin
            tx_buf[i_wr.addr] <= i_wr.data;
        end
        if (o_busy) begin
            o_tx_data <= tx_buf[rd_idx];
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (!i_nreset) begin
            o_busy     <= 1'b0;
            o_tx_valid <= 1'b0;
            rd_idx     <= '0;
        end else begin
            // valid trails busy by one cycle, same as the data
            o_tx_valid <= o_busy;

            if (!o_busy) begin
                // start ignored while streaming
                if (i_start) begin
                    o_busy <= 1'b1;
                    rd_idx <= '0;
                end
            end else begin
                rd_idx <= rd_idx + 1'b1;
                // busy drops on the edge that loads the last byte
                if (rd_idx == `TX_ADDR_W'(`TX_FRAME_BYTES - 1)) begin
                    o_busy <= 1'b0;
                end
            end
        end
    end

endmodule

//--- mii_arp_top.sv
`include "mii_arp_macros.svh"

module mii_arp_top (
    input  logic       i_sys_clk,
    input  logic       i_nreset,
    input  logic       i_rx_enable,
    input  logic       i_rx_dv,
    input  logic [3:0] i_rx_data,
    output logic       o_tx_valid,
    output logic [7:0] o_tx_data
);

    import mii_arp_pkg::*;

    // capture to responder
    rx_status_t            rx_status;
    logic [`RX_ADDR_W-1:0] rd_addr;
    logic [7:0]            rd_data;
    logic                  rx_release;

    // responder to sender
    tx_wr_t                tx_wr;
    logic                  tx_start;
    logic                  tx_busy;

    mii_rx_capture u_capture (
        .i_sys_clk   (i_sys_clk),
        .i_nreset    (i_nreset),
        .i_rx_enable (i_rx_enable),
        .i_rx_dv     (i_rx_dv),
        .i_rx_data   (i_rx_data),
        .i_release   (rx_release),
        .i_rd_addr   (rd_addr),
        .o_status    (rx_status),
        .o_rd_data   (rd_data)
    );

    arp_responder u_responder (
        .i_sys_clk  (i_sys_clk),
        .i_nreset   (i_nreset),
        .i_status   (rx_status),
        .i_rd_data  (rd_data),
        .i_tx_busy  (tx_busy),
        .o_rd_addr  (rd_addr),
        .o_release  (rx_release),
        .o_tx_wr    (tx_wr),
        .o_tx_start (tx_start)
    );

    frame_sender u_sender (
        .i_sys_clk  (i_sys_clk),
        .i_nreset   (i_nreset),
        .i_wr       (tx_wr),
        .i_start    (tx_start),
        .o_busy     (tx_busy),
        .o_tx_valid (o_tx_valid),
        .o_tx_data  (o_tx_data)
    );

endmodule

//--- mii_arp_chk.sv
`include "mii_arp_macros.svh"

module mii_arp_chk (
    input logic       i_sys_clk,
    input logic       i_nreset,
    input logic       i_rx_enable,
    input logic       i_rx_dv,
    input logic [3:0] i_rx_data,
    input logic       i_tx_valid,
    input logic [7:0] i_tx_data
);

    // reference capture, built from the MII pins only
    logic [7:0] cap_buf [`RX_BUF_BYTES];
    logic [3:0] lo_nib;
    logic       last_dv;
    logic       acc;
    logic       half;
    logic [6:0] cap_cnt;

    // reply tracking
    logic       reply_due;
    logic       last_valid;
    logic [6:0] tx_cnt;
    logic [7:0] wait_cnt;
    logic       rst_seen = 1'b0;
    logic [7:0] exp_now;
    int         err_cnt = 0;

    // expected reply byte, straight from the frame layout
    function automatic logic [7:0] exp_byte(input logic [5:0] idx);
        logic [7:0] b;
        case (idx)
            6'd14, 6'd30: b = 8'h12;
            6'd15, 6'd31: b = 8'h34;
            6'd16, 6'd32: b = 8'h56;
            6'd17, 6'd33: b = 8'h78;
            6'd18, 6'd34: b = 8'h9a;
            6'd19, 6'd35: b = 8'hbc;
            // ethertype, then htype ptype hlen plen oper
            6'd20: b = 8'h08;
            6'd21: b = 8'h06;
            6'd22: b = 8'h00;
            6'd23: b = 8'h01;
            6'd24: b = 8'h08;
            6'd25: b = 8'h00;
            6'd26: b = 8'h06;
            6'd27: b = 8'h04;
            6'd28: b = 8'h00;
            6'd29: b = 8'h02;
            // own IP 10.69.69.42
            6'd36: b = 8'd10;
            6'd37: b = 8'd69;
            6'd38: b = 8'd69;
            6'd39: b = 8'd42;
            default: begin
                // preamble echoed, broadcast, then request sender MAC and IP
                if (idx < 6'd8) begin
                    b = cap_buf[idx];
                end else if (idx < 6'd14) begin
                    b = 8'hff;
                end else begin
                    b = cap_buf[idx - 6'd10];
                end
            end
        endcase
        return b;
    endfunction

    always_comb begin
        exp_now = exp_byte(tx_cnt[5:0]);
    end

    always_ff @(posedge i_sys_clk) begin
        rst_seen <= rst_seen || !i_nreset;
    end

    always_ff @(posedge i_sys_clk) begin
        if (!i_nreset) begin
            last_dv    <= 1'b0;
            acc        <= 1'b0;
            half       <= 1'b0;
            cap_cnt    <= '0;
            reply_due  <= 1'b0;
            last_valid <= 1'b0;
            tx_cnt     <= '0;
            wait_cnt   <= '0;
        end else begin
            last_dv    <= i_rx_dv;
            last_valid <= i_tx_valid;

            // frame start, dropped while a reply is still owed
            if (i_rx_dv && !last_dv) begin
                acc     <= i_rx_enable && !reply_due;
                lo_nib  <= i_rx_data;
                half    <= 1'b1;
                cap_cnt <= '0;
            end else if (i_rx_dv && acc) begin
                half <= !half;
                if (!half) begin
                    lo_nib <= i_rx_data;
                end else begin
                    if (cap_cnt < 7'(`RX_BUF_BYTES)) begin
                        cap_buf[cap_cnt[5:0]] <= {i_rx_data, lo_nib};
                    end
                    cap_cnt <= cap_cnt + 7'd1;
                end
            end else if (!i_rx_dv && acc) begin
                acc <= 1'b0;
                // ARP frame seen, reply now owed
                if (cap_cnt > 7'(`ETYPE_LO_OFS)
                        && cap_buf[6'(`ETYPE_HI_OFS)] == `ETYPE_ARP_HI
                        && cap_buf[6'(`ETYPE_LO_OFS)] == `ETYPE_ARP_LO) begin
                    reply_due <= 1'b1;
                    wait_cnt  <= '0;
                end
            end

            // latency count until the first reply byte
            if (reply_due && !i_tx_valid && tx_cnt == 7'd0 && wait_cnt != 8'hff) begin
                wait_cnt <= wait_cnt + 8'd1;
            end

            if (i_tx_valid) begin
                tx_cnt <= tx_cnt + 7'd1;
            end else if (last_valid) begin
                tx_cnt    <= '0;
                reply_due <= 1'b0;
            end
        end
    end

    a_data: assert property (@(posedge i_sys_clk) disable iff (!i_nreset)
        i_tx_valid |-> (i_tx_data == exp_now))
    else begin
        err_cnt++;
        $error("ERR reply_data byte %0d: expected %02h actual %02h",
               $sampled(tx_cnt), $sampled(exp_now), $sampled(i_tx_data));
    end

    // nothing goes out unless an ARP request was taken
    a_owed: assert property (@(posedge i_sys_clk) disable iff (!i_nreset)
        i_tx_valid |-> reply_due)
    else begin
        err_cnt++;
        $error("reply sent with no ARP request outstanding");
    end

    a_len_max: assert property (@(posedge i_sys_clk) disable iff (!i_nreset)
        i_tx_valid |-> (tx_cnt < 7'(`TX_FRAME_BYTES)))
    else begin
        err_cnt++;
        $error("reply longer than %0d bytes", `TX_FRAME_BYTES);
    end

    a_len_min: assert property (@(posedge i_sys_clk) disable iff (!i_nreset)
        (!i_tx_valid && last_valid) |-> (tx_cnt == 7'(`TX_FRAME_BYTES)))
    else begin
        err_cnt++;
        $error("ERR reply_length: expected %0d actual %0d", `TX_FRAME_BYTES, $sampled(tx_cnt));
    end

    // first byte within 110 cycles of dv falling
    a_latency: assert property (@(posedge i_sys_clk) disable iff (!i_nreset)
        (reply_due && tx_cnt == 7'd0) |-> (wait_cnt < 8'd110))
    else begin
        err_cnt++;
        $error("reply did not start within 110 cycles of the request");
    end

    a_reset: assert property (@(posedge i_sys_clk)
        (!i_nreset && rst_seen) |-> !i_tx_valid)
    else begin
        err_cnt++;
        $error("tx valid high during reset");
    end

endmodule

bind mii_arp_top mii_arp_chk u_chk (
    .i_sys_clk   (i_sys_clk),
    .i_nreset    (i_nreset),
    .i_rx_enable (i_rx_enable),
    .i_rx_dv     (i_rx_dv),
    .i_rx_data   (i_rx_data),
    .i_tx_valid  (o_tx_valid),
    .i_tx_data   (o_tx_data)
);

//--- tb_mii_arp.sv
`include "mii_arp_macros.svh"

module tb_mii_arp;

    localparam int N_FRAMES   = 7;
    localparam int MAX_CYCLES = N_FRAMES * 2000;
    // 8 preamble bytes, 14 header bytes, 28 ARP bytes, some padding
    localparam int FRAME_LEN  = 60;

    logic       i_sys_clk;
    logic       i_nreset;
    logic       i_rx_enable;
    logic       i_rx_dv;
    logic [3:0] i_rx_data;
    logic       o_tx_valid;
    logic [7:0] o_tx_data;

    int   frames_sent  = 0;
    int   replies_exp  = 0;
    int   replies_seen = 0;
    int   err_cnt      = 0;
    int   err_total    = 0;
    int   cycle_cnt    = 0;
    logic seen_valid   = 1'b0;

    mii_arp_top i_dut (
        .i_sys_clk   (i_sys_clk),
        .i_nreset    (i_nreset),
        .i_rx_enable (i_rx_enable),
        .i_rx_dv     (i_rx_dv),
        .i_rx_data   (i_rx_data),
        .o_tx_valid  (o_tx_valid),
        .o_tx_data   (o_tx_data)
    );

    initial begin
        i_sys_clk = 1'b0;
        forever #10 i_sys_clk = ~i_sys_clk;
    end

    // reply starts, sampled on the falling edge
    always @(negedge i_sys_clk) begin
        if (o_tx_valid && !seen_valid) begin
            replies_seen++;
        end
        seen_valid = o_tx_valid;
    end

    // run limit
    always @(posedge i_sys_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout, run still going after %0d cycles", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge i_sys_clk);
            #1;
            i_rx_dv   = 1'b0;
            i_rx_data = 4'h0;
        end
    endtask

    task automatic drive_nibble(input logic [3:0] nib);
        @(posedge i_sys_clk);
        #1;
        i_rx_dv   = 1'b1;
        i_rx_data = nib;
    endtask

    // random bytes, low nibble first, ethertype forced
    task automatic send_frame(input logic [7:0] hi, input logic [7:0] lo);
        logic [7:0] b;
        for (int i = 0; i < FRAME_LEN; i++) begin
            b = 8'($urandom());
            if (i == `ETYPE_HI_OFS) begin
                b = hi;
            end
            if (i == `ETYPE_LO_OFS) begin
                b = lo;
            end
            drive_nibble(b[3:0]);
            drive_nibble(b[7:4]);
        end
        frames_sent++;
        idle(2);
    endtask

    task automatic wait_reply(input string name);
        int n;
        n = 0;
        while (!o_tx_valid && n < 200) begin
            @(negedge i_sys_clk);
            n++;
        end
        if (!o_tx_valid) begin
            $display("%s: no reply within %0d cycles", name, n);
            err_cnt++;
        end
        while (o_tx_valid) begin
            @(negedge i_sys_clk);
        end
        idle(4);
    endtask

    task automatic check_count(input string name);
        if (replies_seen != replies_exp) begin
            $display("ERR %s: expected %0d replies actual %0d", name, replies_exp, replies_seen);
            err_cnt++;
            replies_exp = replies_seen;
        end
    endtask

    initial begin
        void'($urandom(32'hf23a));
        i_nreset    = 1'b0;
        i_rx_enable = 1'b1;
        i_rx_dv     = 1'b0;
        i_rx_data   = 4'h0;
        repeat (16) @(posedge i_sys_clk);
        #1;
        i_nreset = 1'b1;

        // quiet line, no reply yet
        idle(40);
        check_count("after_reset");

        send_frame(`ETYPE_ARP_HI, `ETYPE_ARP_LO);
        replies_exp++;
        wait_reply("arp_basic");
        check_count("arp_basic");

        // IPv4 frame ignored, next request still answered
        send_frame(8'h08, 8'h00);
        idle(150);
        check_count("non_arp");
        send_frame(`ETYPE_ARP_HI, `ETYPE_ARP_LO);
        replies_exp++;
        wait_reply("arp_after_non_arp");
        check_count("arp_after_non_arp");

        // receiver switched off for a whole frame
        i_rx_enable = 1'b0;
        send_frame(`ETYPE_ARP_HI, `ETYPE_ARP_LO);
        i_rx_enable = 1'b1;
        idle(150);
        check_count("rx_disabled");

        // second request lands while the first is pending
        send_frame(`ETYPE_ARP_HI, `ETYPE_ARP_LO);
        replies_exp++;
        send_frame(`ETYPE_ARP_HI, `ETYPE_ARP_LO);
        wait_reply("arp_pending");
        idle(150);
        check_count("arp_pending");

        send_frame(`ETYPE_ARP_HI, `ETYPE_ARP_LO);
        replies_exp++;
        wait_reply("arp_final");
        check_count("arp_final");

        err_total = err_cnt + i_dut.u_chk.err_cnt;
        $display("frames sent %0d, replies %0d of %0d, tb errors %0d, assertion failures %0d",
                 frames_sent, replies_seen, replies_exp, err_cnt, i_dut.u_chk.err_cnt);
        if (err_total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+.
mii_arp_pkg.sv
mii_rx_capture.sv
arp_reply_rom.sv
arp_responder.sv
frame_sender.sv
mii_arp_top.sv
mii_arp_chk.sv
tb_mii_arp.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mii_arp
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+1000
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
